/* logic/lsu_pkg.sv */
package lsu_pkg;

// datapath widths.
localparam int XLEN     = 32;
localparam int ADDR_LEN = 32;
localparam int PC_LEN   = 32;
localparam int STRB_LEN = XLEN / 8;
localparam int OFF_LEN  = $clog2(STRB_LEN);   // byte offset within a word.

// data ram geometry with addresses of RAM_WORDS*4 and above out of range.
localparam int RAM_WORDS = 64;
localparam int RAM_AW    = $clog2(RAM_WORDS);

typedef logic [XLEN-1:0]     word_t;
typedef logic [ADDR_LEN-1:0] addr_t;
typedef logic [STRB_LEN-1:0] strb_t;

// byte_i encodings from the core.
localparam strb_t MASK_BYTE = 4'b0001;
localparam strb_t MASK_HALF = 4'b0011;
localparam strb_t MASK_WORD = 4'b1111;

endpackage

/* logic/dmem_if.sv */
`timescale 1ns/1ps

interface dmem_if;

logic                 req;     // one-cycle pulse while busy is low.
lsu_pkg::addr_t       addr;
logic                 wr;
lsu_pkg::strb_t       strb;    // already rotated into word lanes.
lsu_pkg::word_t       wdata;
lsu_pkg::word_t       rdata;   // valid in the cycle busy falls.
logic                 err;
logic                 busy;

modport requester (
    output req,
    output addr,
    output wr,
    output strb,
    output wdata,
    input  rdata,
    input  err,
    input  busy
);

modport memory (
    input  req,
    input  addr,
    input  wr,
    input  strb,
    input  wdata,
    output rdata,
    output err,
    output busy
);

endinterface

/* logic/store_align.sv */
`timescale 1ns/1ps

module store_align (
    input  lsu_pkg::addr_t    addr_i,
    input  lsu_pkg::strb_t    byte_i,
    input  lsu_pkg::word_t    wdata_i,
    output logic              misaligned_o,
    output lsu_pkg::strb_t    strb_o,
    output lsu_pkg::word_t    wdata_o
);

logic [lsu_pkg::OFF_LEN-1:0] off;

assign off = addr_i[lsu_pkg::OFF_LEN-1:0];

// half-word needs an even offset and word needs offset 0.
assign misaligned_o = ((byte_i == lsu_pkg::MASK_HALF) && off[0]) ||
                      ((byte_i == lsu_pkg::MASK_WORD) && (off != '0));

// rotate left by the byte offset.
always_comb begin
    case (off)
        2'd1: begin
            strb_o  = {byte_i[2:0], byte_i[3]};
            wdata_o = {wdata_i[23:0], wdata_i[31:24]};
        end
        2'd2: begin
            strb_o  = {byte_i[1:0], byte_i[3:2]};
            wdata_o = {wdata_i[15:0], wdata_i[31:16]};
        end
        2'd3: begin
            strb_o  = {byte_i[0], byte_i[3:1]};
            wdata_o = {wdata_i[7:0], wdata_i[31:8]};
        end
        default: begin
            strb_o  = byte_i;
            wdata_o = wdata_i;
        end
    endcase
end

endmodule

/* logic/load_align.sv */
`timescale 1ns/1ps

module load_align (
    input  logic [lsu_pkg::OFF_LEN-1:0] offset_i,
    input  lsu_pkg::strb_t              mask_i,
    input  logic                        sign_ext_i,
    input  lsu_pkg::word_t              rdata_i,
    output lsu_pkg::word_t              ext_data_o
);

lsu_pkg::word_t rot;

// rotate right so the addressed byte lands in lane 0.
always_comb begin
    case (offset_i)
        2'd1: begin
            rot = {rdata_i[7:0], rdata_i[31:8]};
        end
        2'd2: begin
            rot = {rdata_i[15:0], rdata_i[31:16]};
        end
        2'd3: begin
            rot = {rdata_i[23:0], rdata_i[31:24]};
        end
        default: begin
            rot = rdata_i;
        end
    endcase
end

always_comb begin
    case (mask_i)
        lsu_pkg::MASK_WORD: begin
            ext_data_o = rot;
        end
        lsu_pkg::MASK_HALF: begin
            ext_data_o = {{16{sign_ext_i & rot[15]}}, rot[15:0]};
        end
        lsu_pkg::MASK_BYTE: begin
            ext_data_o = {{24{sign_ext_i & rot[7]}}, rot[7:0]};
        end
        default: begin
            ext_data_o = '0;   // unknown mask gives zero.
        end
    endcase
end

endmodule

/* logic/lsu_ctrl.sv */
`timescale 1ns/1ps

module lsu_ctrl (
    input  logic                          clk,
    input  logic                          rstn,

    input  logic [lsu_pkg::PC_LEN-1:0]    pc_i,
    input  logic                          req_i,
    input  logic                          wr_i,
    input  logic                          sign_ext_i,
    input  lsu_pkg::strb_t                byte_i,
    input  lsu_pkg::addr_t                addr_i,

    input  logic                          misaligned_i,
    input  lsu_pkg::strb_t                strb_i,
    input  lsu_pkg::word_t                wdata_i,
    input  lsu_pkg::word_t                ext_data_i,

    dmem_if.requester                     dmem,

    output logic [lsu_pkg::OFF_LEN-1:0]   offset_o,
    output lsu_pkg::strb_t                mask_o,
    output logic                          sign_ext_o,
    output lsu_pkg::word_t                rdata_o,
    output logic                          hazard_o,

    output logic                          fault_o,
    output logic                          load_misaligned_o,
    output logic                          store_misaligned_o,
    output logic                          load_access_fault_o,
    output logic                          store_access_fault_o,
    output lsu_pkg::addr_t                bad_addr_o,
    output logic [lsu_pkg::PC_LEN-1:0]    fault_pc_o
);

logic           accept;
logic           done;
logic           load_done;
logic           pending;
logic           kind_wr;   // kind of the pending access.
lsu_pkg::word_t data_latch;

assign accept    = req_i & ~misaligned_i & ~pending;
assign done      = pending & ~dmem.busy;
assign load_done = done & ~kind_wr & ~dmem.err;

// a held request keeps the core stalled through the completion cycle.
assign hazard_o = pending & (~done | (req_i & ~misaligned_i));

assign dmem.req   = accept;
assign dmem.addr  = addr_i;
assign dmem.wr    = wr_i;
assign dmem.strb  = strb_i;
assign dmem.wdata = wdata_i;

assign rdata_o = load_done ? ext_data_i : data_latch;

assign load_access_fault_o  = done & dmem.err & ~kind_wr;
assign store_access_fault_o = done & dmem.err &  kind_wr;
assign fault_o = load_access_fault_o | store_access_fault_o |
                 load_misaligned_o | store_misaligned_o;

always_ff @(posedge clk or negedge rstn) begin
    if (~rstn) begin
        pending <= 1'b0;
        kind_wr <= 1'b0;
    end else if (accept) begin
        pending <= 1'b1;
        kind_wr <= wr_i;
    end else if (done) begin
        pending <= 1'b0;
    end
end

always_ff @(posedge clk or negedge rstn) begin
    if (~rstn) begin
        load_misaligned_o  <= 1'b0;
        store_misaligned_o <= 1'b0;
    end else begin
        load_misaligned_o  <= req_i & misaligned_i & ~wr_i;
        store_misaligned_o <= req_i & misaligned_i &  wr_i;
    end
end

always_ff @(posedge clk or negedge rstn) begin
    if (~rstn) begin
        bad_addr_o <= '0;
        fault_pc_o <= '0;
        data_latch <= '0;
    end else begin
        if (accept | (req_i & misaligned_i)) begin
            bad_addr_o <= addr_i;
            fault_pc_o <= pc_i;
        end
        if (load_done) begin
            data_latch <= ext_data_i;
        end
    end
end

// load_align settings for the pending access.
always_ff @(posedge clk) begin
    if (accept) begin
        offset_o   <= addr_i[lsu_pkg::OFF_LEN-1:0];
        mask_o     <= byte_i;
        sign_ext_o <= sign_ext_i;
    end
end

endmodule

/* logic/apb_dmem_master.sv */
`timescale 1ns/1ps

module apb_dmem_master (
    input  logic              clk,
    input  logic              rstn,

    dmem_if.memory            dmem,

    output logic              psel_o,
    output logic              penable_o,
    output logic              pwrite_o,
    output lsu_pkg::addr_t    paddr_o,
    output lsu_pkg::word_t    pwdata_o,
    output lsu_pkg::strb_t    pstrb_o,
    input  lsu_pkg::word_t    prdata_i,
    input  logic              pready_i,
    input  logic              pslverr_i
);

typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
} state_t;

state_t         state;
state_t         state_nxt;
logic           access_done;
logic           wr_q;
lsu_pkg::addr_t addr_q;
lsu_pkg::word_t wdata_q;
lsu_pkg::strb_t strb_q;

assign access_done = (state == ST_ACCESS) & pready_i;

always_comb begin
    state_nxt = state;
    case (state)
        ST_IDLE: begin
            if (dmem.req) begin
                state_nxt = ST_SETUP;
            end
        end
        ST_SETUP: begin
            state_nxt = ST_ACCESS;
        end
        ST_ACCESS: begin
            if (pready_i) begin
                state_nxt = dmem.req ? ST_SETUP : ST_IDLE;   // back to back allowed.
            end
        end
        default: begin
            state_nxt = ST_IDLE;
        end
    endcase
end

always_ff @(posedge clk or negedge rstn) begin
    if (~rstn) begin
        state <= ST_IDLE;
    end else begin
        state <= state_nxt;
    end
end

// request is held steady through setup and access.
always_ff @(posedge clk) begin
    if (dmem.req) begin
        wr_q    <= dmem.wr;
        addr_q  <= dmem.addr;
        wdata_q <= dmem.wdata;
        strb_q  <= dmem.strb;
    end
end

assign psel_o    = (state != ST_IDLE);
assign penable_o = (state == ST_ACCESS);
assign pwrite_o  = wr_q;
assign paddr_o   = addr_q;
assign pwdata_o  = wdata_q;
assign pstrb_o   = wr_q ? strb_q : '0;   // reads carry no strobes.

assign dmem.busy  = (state == ST_SETUP) | ((state == ST_ACCESS) & ~pready_i);
assign dmem.rdata = prdata_i;
assign dmem.err   = access_done & pslverr_i;

endmodule

/* logic/data_ram.sv */
`timescale 1ns/1ps

module data_ram (
    input  logic              clk,
    input  logic              rstn,

    input  logic              psel_i,
    input  logic              penable_i,
    input  logic              pwrite_i,
    input  lsu_pkg::addr_t    paddr_i,
    input  lsu_pkg::word_t    pwdata_i,
    input  lsu_pkg::strb_t    pstrb_i,
    output lsu_pkg::word_t    prdata_o,
    output logic              pready_o,
    output logic              pslverr_o
);

lsu_pkg::word_t               mem [lsu_pkg::RAM_WORDS];
logic [lsu_pkg::RAM_AW-1:0]   idx;
logic                         in_range;
logic                         setup;
logic                         access;

assign idx      = paddr_i[lsu_pkg::RAM_AW+1:2];
assign in_range = ~|paddr_i[lsu_pkg::ADDR_LEN-1:lsu_pkg::RAM_AW+2];
assign setup    = psel_i & ~penable_i;
assign access   = psel_i &  penable_i;

assign pready_o = 1'b1;   // no wait states.

// error is decided in setup and shown through the access phase.
always_ff @(posedge clk or negedge rstn) begin
    if (~rstn) begin
        pslverr_o <= 1'b0;
    end else begin
        pslverr_o <= setup & ~in_range;
    end
end

always_ff @(posedge clk) begin
    if (setup & ~pwrite_i) begin
        prdata_o <= in_range ? mem[idx] : '0;
    end
    if (access & pwrite_i & in_range) begin
        for (int b = 0; b < lsu_pkg::STRB_LEN; b++) begin
            if (pstrb_i[b]) begin
                mem[idx][8*b +: 8] <= pwdata_i[8*b +: 8];
            end
        end
    end
end

endmodule

/* logic/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top (
    input  logic                          clk,
    input  logic                          rstn,

    input  logic [lsu_pkg::PC_LEN-1:0]    pc_i,
    input  logic                          req_i,
    input  logic                          wr_i,
    input  logic                          sign_ext_i,
    input  lsu_pkg::strb_t                byte_i,
    input  lsu_pkg::addr_t                addr_i,
    input  lsu_pkg::word_t                wdata_i,

    output lsu_pkg::word_t                rdata_o,
    output logic                          hazard_o,
    output logic                          fault_o,
    output logic                          load_misaligned_o,
    output logic                          store_misaligned_o,
    output logic                          load_access_fault_o,
    output logic                          store_access_fault_o,
    output lsu_pkg::addr_t                bad_addr_o,
    output logic [lsu_pkg::PC_LEN-1:0]    fault_pc_o
);

logic                         misaligned;
lsu_pkg::strb_t               st_strb;
lsu_pkg::word_t               st_wdata;
lsu_pkg::word_t               ext_data;
logic [lsu_pkg::OFF_LEN-1:0]  ld_offset;
lsu_pkg::strb_t               ld_mask;
logic                         ld_sign_ext;

logic                         psel;
logic                         penable;
logic                         pwrite;
lsu_pkg::addr_t               paddr;
lsu_pkg::word_t               pwdata;
lsu_pkg::strb_t               pstrb;
lsu_pkg::word_t               prdata;
logic                         pready;
logic                         pslverr;

dmem_if dmem_bus ();

store_align u_store_align (
    .addr_i       (addr_i),
    .byte_i       (byte_i),
    .wdata_i      (wdata_i),
    .misaligned_o (misaligned),
    .strb_o       (st_strb),
    .wdata_o      (st_wdata)
);

lsu_ctrl u_lsu_ctrl (
    .clk                  (clk),
    .rstn                 (rstn),
    .pc_i                 (pc_i),
    .req_i                (req_i),
    .wr_i                 (wr_i),
    .sign_ext_i           (sign_ext_i),
    .byte_i               (byte_i),
    .addr_i               (addr_i),
    .misaligned_i         (misaligned),
    .strb_i               (st_strb),
    .wdata_i              (st_wdata),
    .ext_data_i           (ext_data),
    .dmem                 (dmem_bus.requester),
    .offset_o             (ld_offset),
    .mask_o               (ld_mask),
    .sign_ext_o           (ld_sign_ext),
    .rdata_o              (rdata_o),
    .hazard_o             (hazard_o),
    .fault_o              (fault_o),
    .load_misaligned_o    (load_misaligned_o),
    .store_misaligned_o   (store_misaligned_o),
    .load_access_fault_o  (load_access_fault_o),
    .store_access_fault_o (store_access_fault_o),
    .bad_addr_o           (bad_addr_o),
    .fault_pc_o           (fault_pc_o)
);

load_align u_load_align (
    .offset_i   (ld_offset),
    .mask_i     (ld_mask),
    .sign_ext_i (ld_sign_ext),
    .rdata_i    (dmem_bus.rdata),
    .ext_data_o (ext_data)
);

apb_dmem_master u_apb_master (
    .clk       (clk),
    .rstn      (rstn),
    .dmem      (dmem_bus.memory),
    .psel_o    (psel),
    .penable_o (penable),
    .pwrite_o  (pwrite),
    .paddr_o   (paddr),
    .pwdata_o  (pwdata),
    .pstrb_o   (pstrb),
    .prdata_i  (prdata),
    .pready_i  (pready),
    .pslverr_i (pslverr)
);

data_ram u_data_ram (
    .clk       (clk),
    .rstn      (rstn),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .pstrb_i   (pstrb),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr)
);

endmodule

/* dv/lsu_tb_table.svh */
// one row per access, applied in order by the testbench.
// a row gives name, address, mask, write flag, sign flag, random flag,
// data, pc, expected load data and expected fault kind.
// random stores take $random data and random loads expect the last random store.

typedef struct packed {
    lsu_pkg::addr_t             addr;
    lsu_pkg::strb_t             mask;
    logic                       wr;
    logic                       sign;
    logic                       rnd;
    lsu_pkg::word_t             data;
    logic [lsu_pkg::PC_LEN-1:0] pc;
    lsu_pkg::word_t             exp;
    logic [2:0]                 kind;
} row_t;

localparam logic [2:0] FK_NONE   = 3'd0;
localparam logic [2:0] FK_LD_MIS = 3'd1;
localparam logic [2:0] FK_ST_MIS = 3'd2;
localparam logic [2:0] FK_LD_ACC = 3'd3;
localparam logic [2:0] FK_ST_ACC = 3'd4;

localparam lsu_pkg::strb_t M_B = lsu_pkg::MASK_BYTE;
localparam lsu_pkg::strb_t M_H = lsu_pkg::MASK_HALF;
localparam lsu_pkg::strb_t M_W = lsu_pkg::MASK_WORD;

localparam logic LD  = 1'b0;
localparam logic ST  = 1'b1;
localparam logic ZX  = 1'b0;
localparam logic SX  = 1'b1;
localparam logic FIX = 1'b0;
localparam logic RND = 1'b1;

row_t  rows [$];
string row_names [$];

task automatic add_row(input string name, input lsu_pkg::addr_t addr,
                       input lsu_pkg::strb_t mask, input logic wr, input logic sign,
                       input logic rnd, input lsu_pkg::word_t data,
                       input logic [lsu_pkg::PC_LEN-1:0] pc, input lsu_pkg::word_t exp,
                       input logic [2:0] kind);
    row_t r;

    r.addr = addr;
    r.mask = mask;
    r.wr   = wr;
    r.sign = sign;
    r.rnd  = rnd;
    r.data = data;
    r.pc   = pc;
    r.exp  = exp;
    r.kind = kind;
    rows.push_back(r);
    row_names.push_back(name);
endtask

task automatic fill_table();
    add_row("sw_word0",      'h0,        M_W, ST, ZX, FIX, 'h11223344, 'h1000, 'h0, FK_NONE);
    add_row("lw_word0",      'h0,        M_W, LD, ZX, FIX, 'h0, 'h1004, 'h11223344, FK_NONE);
    add_row("sb_off1",       'h1,        M_B, ST, ZX, FIX, 'hffffffab, 'h1008, 'h0, FK_NONE);
    add_row("sh_off2",       'h2,        M_H, ST, ZX, FIX, 'hdead8765, 'h100c, 'h0, FK_NONE);
    add_row("lw_word0_mix",  'h0,        M_W, LD, ZX, FIX, 'h0, 'h1010, 'h8765ab44, FK_NONE);
    add_row("lb_off1_s",     'h1,        M_B, LD, SX, FIX, 'h0, 'h1014, 'hffffffab, FK_NONE);
    add_row("lbu_off1",      'h1,        M_B, LD, ZX, FIX, 'h0, 'h1018, 'h000000ab, FK_NONE);
    add_row("lh_off2_s",     'h2,        M_H, LD, SX, FIX, 'h0, 'h101c, 'hffff8765, FK_NONE);
    add_row("lhu_off2",      'h2,        M_H, LD, ZX, FIX, 'h0, 'h1020, 'h00008765, FK_NONE);
    add_row("lb_off0_s",     'h0,        M_B, LD, SX, FIX, 'h0, 'h1024, 'h00000044, FK_NONE);
    add_row("lb_off3_s",     'h3,        M_B, LD, SX, FIX, 'h0, 'h1028, 'hffffff87, FK_NONE);
    add_row("lh_off0_s",     'h0,        M_H, LD, SX, FIX, 'h0, 'h102c, 'hffffab44, FK_NONE);
    add_row("sw_word4",      'h10,       M_W, ST, ZX, FIX, 'h00000000, 'h1030, 'h0, FK_NONE);
    add_row("sb_off0",       'h10,       M_B, ST, ZX, FIX, 'h1234567f, 'h1034, 'h0, FK_NONE);
    add_row("sb_off2",       'h12,       M_B, ST, ZX, FIX, 'h000000c3, 'h1038, 'h0, FK_NONE);
    add_row("sb_off3",       'h13,       M_B, ST, ZX, FIX, 'h0000005a, 'h103c, 'h0, FK_NONE);
    add_row("sh_off0",       'h10,       M_H, ST, ZX, FIX, 'hffff1234, 'h1040, 'h0, FK_NONE);
    add_row("lw_word4",      'h10,       M_W, LD, ZX, FIX, 'h0, 'h1044, 'h5ac31234, FK_NONE);
    add_row("lb_off2_s",     'h12,       M_B, LD, SX, FIX, 'h0, 'h1048, 'hffffffc3, FK_NONE);
    add_row("lh_off2_pos",   'h12,       M_H, LD, SX, FIX, 'h0, 'h104c, 'h00005ac3, FK_NONE);
    add_row("lh_mis1",       'h11,       M_H, LD, SX, FIX, 'h0, 'h2000, 'h0, FK_LD_MIS);
    add_row("sh_mis3",       'h13,       M_H, ST, ZX, FIX, 'hffffffff, 'h2004, 'h0, FK_ST_MIS);
    add_row("sw_mis2",       'h12,       M_W, ST, ZX, FIX, 'hffffffff, 'h2008, 'h0, FK_ST_MIS);
    add_row("lw_mis1",       'h11,       M_W, LD, ZX, FIX, 'h0, 'h200c, 'h0, FK_LD_MIS);
    add_row("sw_mis3",       'h13,       M_W, ST, ZX, FIX, 'hffffffff, 'h2010, 'h0, FK_ST_MIS);
    add_row("lw_word4_chk",  'h10,       M_W, LD, ZX, FIX, 'h0, 'h2014, 'h5ac31234, FK_NONE);
    add_row("sw_oor256",     'h100,      M_W, ST, ZX, FIX, 'hbadbad00, 'h2018, 'h0, FK_ST_ACC);
    add_row("lw_oor260",     'h104,      M_W, LD, ZX, FIX, 'h0, 'h201c, 'h0, FK_LD_ACC);
    add_row("sb_oor_high",   'h80000010, M_B, ST, ZX, FIX, 'h000000ee, 'h2020, 'h0, FK_ST_ACC);
    add_row("lh_oor_top",    'hfffffffe, M_H, LD, SX, FIX, 'h0, 'h2024, 'h0, FK_LD_ACC);
    add_row("lw_word0_chk",  'h0,        M_W, LD, ZX, FIX, 'h0, 'h2028, 'h8765ab44, FK_NONE);
    add_row("lw_word4_chk2", 'h10,       M_W, LD, ZX, FIX, 'h0, 'h202c, 'h5ac31234, FK_NONE);
    add_row("sw_top",        'hfc,       M_W, ST, ZX, FIX, 'ha5a55a5a, 'h3000, 'h0, FK_NONE);
    add_row("lh_top_s",      'hfe,       M_H, LD, SX, FIX, 'h0, 'h3004, 'hffffa5a5, FK_NONE);
    add_row("lb_top_s",      'hfc,       M_B, LD, SX, FIX, 'h0, 'h3008, 'h0000005a, FK_NONE);
    add_row("sw_rand",       'h20,       M_W, ST, ZX, RND, 'h0, 'h300c, 'h0, FK_NONE);
    add_row("lw_rand",       'h20,       M_W, LD, ZX, RND, 'h0, 'h3010, 'h0, FK_NONE);
    add_row("sw_rand2",      'hf8,       M_W, ST, ZX, RND, 'h0, 'h3014, 'h0, FK_NONE);
    add_row("lw_rand2",      'hf8,       M_W, LD, ZX, RND, 'h0, 'h3018, 'h0, FK_NONE);
endtask

/* dv/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb;

localparam int RESET_CYCLES = 16;
localparam int HALF_PERIOD  = 20;
localparam int DRIVE_DELAY  = 2;

logic                       clk;
logic                       rstn;
logic [lsu_pkg::PC_LEN-1:0] pc_i;
logic                       req_i;
logic                       wr_i;
logic                       sign_ext_i;
lsu_pkg::strb_t             byte_i;
lsu_pkg::addr_t             addr_i;
lsu_pkg::word_t             wdata_i;

lsu_pkg::word_t             rdata_o;
logic                       hazard_o;
logic                       fault_o;
logic                       load_misaligned_o;
logic                       store_misaligned_o;
logic                       load_access_fault_o;
logic                       store_access_fault_o;
lsu_pkg::addr_t             bad_addr_o;
logic [lsu_pkg::PC_LEN-1:0] fault_pc_o;

int             err_count    = 0;
int             tests_passed = 0;
int             tests_failed = 0;
int             cycle_count  = 0;
int             cycle_limit  = 0;
integer         seed;
lsu_pkg::word_t last_rnd;

`include "lsu_tb_table.svh"

lsu_top UUT (.*);

initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
end

// watchdog limit is set once the table is known.
always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
        $display("timeout after %0d cycles, the DUT stopped answering", cycle_count);
        $display("TESTBENCH FAILED");
        $finish;
    end
end

task automatic check_word(input string name, input string what,
                          input lsu_pkg::word_t exp, input lsu_pkg::word_t act);
    if (act !== exp) begin
        $display("ERROR %s %s expected %h actual %h", name, what, exp, act);
        err_count++;
    end
endtask

task automatic check_addr(input string name, input string what,
                          input lsu_pkg::addr_t exp, input lsu_pkg::addr_t act);
    if (act !== exp) begin
        $display("ERROR %s %s expected %h actual %h", name, what, exp, act);
        err_count++;
    end
endtask

task automatic check_pc(input string name, input string what,
                        input logic [lsu_pkg::PC_LEN-1:0] exp,
                        input logic [lsu_pkg::PC_LEN-1:0] act);
    if (act !== exp) begin
        $display("ERROR %s %s expected %h actual %h", name, what, exp, act);
        err_count++;
    end
endtask

task automatic check_flag(input string name, input string what,
                          input logic exp, input logic act);
    if (act !== exp) begin
        $display("ERROR %s %s expected %b actual %b", name, what, exp, act);
        err_count++;
    end
endtask

task automatic drive_idle();
    req_i      = 1'b0;
    wr_i       = 1'b0;
    sign_ext_i = 1'b0;
    byte_i     = '0;
    addr_i     = '0;
    wdata_i    = '0;
    pc_i       = '0;
endtask

// counts falling edges up to and including the first one with hazard_o low.
task automatic wait_hazard_low(output int cycles);
    cycles = 0;
    do begin
        @(negedge clk);
        cycles++;
    end while (hazard_o !== 1'b0);
endtask

task automatic report_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
        tests_passed++;
        $display("test %-14s ok", name);
    end else begin
        tests_failed++;
        $display("test %-14s failed", name);
    end
endtask

task automatic expect_stall(input string name, input int exp, input int act);
    if (act != exp) begin
        $display("ERROR %s stall cycles expected %0d actual %0d", name, exp, act);
        err_count++;
    end
endtask

task automatic verify_reset_state();
    int errs_before;

    errs_before = err_count;
    check_flag("reset", "hazard_o", 1'b0, hazard_o);
    check_flag("reset", "fault_o", 1'b0, fault_o);
    check_flag("reset", "load_misaligned_o", 1'b0, load_misaligned_o);
    check_flag("reset", "store_misaligned_o", 1'b0, store_misaligned_o);
    check_flag("reset", "load_access_fault_o", 1'b0, load_access_fault_o);
    check_flag("reset", "store_access_fault_o", 1'b0, store_access_fault_o);
    check_flag("reset", "psel", 1'b0, UUT.psel);
    check_flag("reset", "penable", 1'b0, UUT.penable);
    check_flag("reset", "dmem req", 1'b0, UUT.dmem_bus.req);
    report_test("reset", errs_before);
endtask

task automatic apply_row(input int i);
    row_t           r;
    string          name;
    lsu_pkg::word_t data;
    lsu_pkg::word_t exp_data;
    logic           misaligned;
    int             stall;
    int             errs_before;

    r           = rows[i];
    name        = row_names[i];
    errs_before = err_count;
    data        = r.data;
    exp_data    = r.exp;
    if (r.rnd && r.wr) begin
        data     = $random(seed);
        last_rnd = data;
    end else if (r.rnd) begin
        exp_data = last_rnd;
    end
    misaligned = (r.kind == FK_LD_MIS) || (r.kind == FK_ST_MIS);

    @(posedge clk);
    #DRIVE_DELAY;
    pc_i       = r.pc;
    addr_i     = r.addr;
    byte_i     = r.mask;
    wr_i       = r.wr;
    sign_ext_i = r.sign;
    wdata_i    = data;
    req_i      = 1'b1;
    wait_hazard_low(stall);   // request goes in at the next edge.
    @(posedge clk);
    #DRIVE_DELAY;
    req_i = 1'b0;

    // misaligned requests are flagged one cycle later and accesses complete after two.
    wait_hazard_low(stall);
    expect_stall(name, misaligned ? 1 : 2, stall);
    check_flag(name, "fault_o", r.kind != FK_NONE, fault_o);
    check_flag(name, "load_misaligned_o", r.kind == FK_LD_MIS, load_misaligned_o);
    check_flag(name, "store_misaligned_o", r.kind == FK_ST_MIS, store_misaligned_o);
    check_flag(name, "load_access_fault_o", r.kind == FK_LD_ACC, load_access_fault_o);
    check_flag(name, "store_access_fault_o", r.kind == FK_ST_ACC, store_access_fault_o);
    check_addr(name, "bad_addr_o", r.addr, bad_addr_o);
    check_pc(name, "fault_pc_o", r.pc, fault_pc_o);
    if (!r.wr && r.kind == FK_NONE) begin
        check_word(name, "rdata_o", exp_data, rdata_o);
        @(negedge clk);
        check_word(name, "rdata_o held", exp_data, rdata_o);
    end
    report_test(name, errs_before);
endtask

// a load held on req_i while the store before it is still pending.
task automatic run_held_request();
    string          name;
    lsu_pkg::addr_t addr;
    lsu_pkg::word_t data;
    int             stall;
    int             errs_before;

    name        = "held_load";
    addr        = 32'h00000040;
    data        = $random(seed);
    errs_before = err_count;

    @(posedge clk);
    #DRIVE_DELAY;
    pc_i       = 32'h00004000;
    addr_i     = addr;
    byte_i     = lsu_pkg::MASK_WORD;
    wr_i       = 1'b1;
    sign_ext_i = 1'b0;
    wdata_i    = data;
    req_i      = 1'b1;
    wait_hazard_low(stall);
    @(posedge clk);
    #DRIVE_DELAY;
    pc_i = 32'h00004004;
    wr_i = 1'b0;
    wait_hazard_low(stall);
    expect_stall(name, 3, stall);   // two stalled cycles behind the store.
    @(posedge clk);
    #DRIVE_DELAY;
    req_i = 1'b0;
    wait_hazard_low(stall);
    expect_stall(name, 2, stall);
    check_word(name, "rdata_o", data, rdata_o);
    check_flag(name, "fault_o", 1'b0, fault_o);
    check_addr(name, "bad_addr_o", addr, bad_addr_o);
    check_pc(name, "fault_pc_o", 32'h00004004, fault_pc_o);
    report_test(name, errs_before);
endtask

initial begin
    seed     = 32'h7300;
    last_rnd = '0;
    rstn     = 1'b0;
    drive_idle();
    fill_table();
    cycle_limit = (rows.size() + 1) * 10 + RESET_CYCLES;

    repeat (RESET_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    verify_reset_state();
    @(posedge clk);
    #DRIVE_DELAY;
    rstn = 1'b1;

    for (int i = 0; i < rows.size(); i++) begin
        apply_row(i);
    end
    run_held_request();

    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             tests_passed + tests_failed, tests_passed, tests_failed, err_count);
    if (tests_failed == 0 && err_count == 0) begin
        $display("TESTBENCH PASSED");
    end else begin
        $display("TESTBENCH FAILED");
    end
    $finish;
end

endmodule

/* project.f */
+incdir+dv
logic/lsu_pkg.sv
logic/dmem_if.sv
logic/store_align.sv
logic/load_align.sv
logic/lsu_ctrl.sv
logic/apb_dmem_master.sv
logic/data_ram.sv
logic/lsu_top.sv
dv/lsu_tb.sv

/* run.sh */
#!/bin/sh
# builds the LSU testbench with Verilator and runs it once.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module lsu_tb -f project.f -o lsu_sim || exit 1

out="$(./obj_dir/lsu_sim)"
echo "$out"

echo "$out" | grep -q "TESTBENCH PASSED" && exit 0 || exit 1
